//--- design/matmul_pkg.sv
package matmul_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // data and memory geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int DWIDTH     = 8;
  localparam int AWIDTH     = 15;
  localparam int MAT_SIZE   = 4;
  localparam int WORD_WIDTH = MAT_SIZE * DWIDTH;
  localparam int MEM_SIZE   = 32768;

  localparam logic [AWIDTH-1:0] ADDR_STEP = AWIDTH'(4);
  // one step before address 0, so the first increment wraps onto word 0
  localparam logic [AWIDTH-1:0] ADDR_IDLE = AWIDTH'(MEM_SIZE - 4);

  ////////////////////////////////////////////////////////////////////////////
  // phase lengths
  ////////////////////////////////////////////////////////////////////////////

  localparam int MAC_STAGES = 3;
  // memory latency + lane skew + hops across the grid + mac pipeline
  localparam int COMPUTE_CYCLES = 1 + (MAT_SIZE - 1) + (MAT_SIZE - 1) + MAC_STAGES;
  localparam int CNT_WIDTH  = 4;

  // last count of the load/drain phases and of the compute phase
  localparam logic [CNT_WIDTH-1:0] MAT_LAST     = CNT_WIDTH'(MAT_SIZE - 1);
  localparam logic [CNT_WIDTH-1:0] COMPUTE_LAST = CNT_WIDTH'(COMPUTE_CYCLES - 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD,
    ST_COMPUTE,
    ST_DRAIN,
    ST_DONE
  } ctrl_state_t;

endpackage

//--- design/mac_unit.sv
`timescale 1ns/1ps

module mac_unit (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                i_clear,
  input  logic signed [matmul_pkg::DWIDTH-1:0] i_a,
  input  logic signed [matmul_pkg::DWIDTH-1:0] i_b,
  output logic signed [matmul_pkg::DWIDTH-1:0] o_acc
);

  logic signed [matmul_pkg::DWIDTH-1:0]   a_q;
  logic signed [matmul_pkg::DWIDTH-1:0]   b_q;
  logic signed [2*matmul_pkg::DWIDTH-1:0] product;
  logic signed [2*matmul_pkg::DWIDTH-1:0] prod_q;
  logic signed [matmul_pkg::DWIDTH-1:0]   prod_sat;
  logic                                   prod_fits;

  // full width signed product of the flopped operands
  assign product = $signed({{matmul_pkg::DWIDTH{a_q[matmul_pkg::DWIDTH-1]}}, a_q}) *
                   $signed({{matmul_pkg::DWIDTH{b_q[matmul_pkg::DWIDTH-1]}}, b_q});

  // fits in the narrow range when the sign and all upper bits agree
  assign prod_fits = (&prod_q[2*matmul_pkg::DWIDTH-1:matmul_pkg::DWIDTH-1]) |
                     ~(|prod_q[2*matmul_pkg::DWIDTH-1:matmul_pkg::DWIDTH-1]);

  always_comb begin
    if (prod_fits) begin
      prod_sat = prod_q[matmul_pkg::DWIDTH-1:0];
    end else if (prod_q[2*matmul_pkg::DWIDTH-1]) begin
      prod_sat = {1'b1, {(matmul_pkg::DWIDTH-1){1'b0}}};
    end else begin
      prod_sat = {1'b0, {(matmul_pkg::DWIDTH-1){1'b1}}};
    end
  end

  // operand flop, product flop, then accumulate modulo 2**DWIDTH
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      a_q    <= '0;
      b_q    <= '0;
      prod_q <= '0;
      o_acc  <= '0;
    end else begin
      a_q    <= i_a;
      b_q    <= i_b;
      prod_q <= product;
      o_acc  <= o_acc + prod_sat;
    end
  end

endmodule

//--- design/processing_element.sv
`timescale 1ns/1ps

module processing_element (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         i_clear,
  input  logic [matmul_pkg::DWIDTH-1:0] i_a,
  input  logic [matmul_pkg::DWIDTH-1:0] i_b,
  output logic [matmul_pkg::DWIDTH-1:0] o_a,
  output logic [matmul_pkg::DWIDTH-1:0] o_b,
  output logic [matmul_pkg::DWIDTH-1:0] o_c
);

  mac_unit u_mac (
    .clk     (clk),
    .reset   (reset),
    .i_clear (i_clear),
    .i_a     (i_a),
    .i_b     (i_b),
    .o_acc   (o_c)
  );

  // one hop to the right for a, one hop down for b
  always_ff @(posedge clk) begin
    if (reset) begin
      o_a <= '0;
      o_b <= '0;
    end else begin
      o_a <= i_a;
      o_b <= i_b;
    end
  end

endmodule

//--- design/systolic_array.sv
`timescale 1ns/1ps

module systolic_array (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    i_clear,
  input  logic [matmul_pkg::WORD_WIDTH-1:0]       i_a_lanes,
  input  logic [matmul_pkg::WORD_WIDTH-1:0]       i_b_lanes,
  output logic [matmul_pkg::MAT_SIZE*matmul_pkg::MAT_SIZE*matmul_pkg::DWIDTH-1:0] o_results
);

  // a_link[r][c] feeds the cell at (r, c); column MAT_SIZE is the far edge
  logic [matmul_pkg::DWIDTH-1:0] a_link [matmul_pkg::MAT_SIZE][matmul_pkg::MAT_SIZE+1];
  // b_link[r][c] feeds the cell at (r, c); row MAT_SIZE is the bottom edge
  logic [matmul_pkg::DWIDTH-1:0] b_link [matmul_pkg::MAT_SIZE+1][matmul_pkg::MAT_SIZE];

  genvar r;
  genvar c;

  ////////////////////////////////////////////////////////////////////////////
  // edge inputs
  ////////////////////////////////////////////////////////////////////////////

  for (r = 0; r < matmul_pkg::MAT_SIZE; r++) begin : g_left
    assign a_link[r][0] = i_a_lanes[r*matmul_pkg::DWIDTH +: matmul_pkg::DWIDTH];
  end

  for (c = 0; c < matmul_pkg::MAT_SIZE; c++) begin : g_top
    assign b_link[0][c] = i_b_lanes[c*matmul_pkg::DWIDTH +: matmul_pkg::DWIDTH];
  end

  ////////////////////////////////////////////////////////////////////////////
  // cell grid
  ////////////////////////////////////////////////////////////////////////////

  for (r = 0; r < matmul_pkg::MAT_SIZE; r++) begin : g_row
    for (c = 0; c < matmul_pkg::MAT_SIZE; c++) begin : g_col
      // operands that reach the far edge are not read by anything
      processing_element u_pe (
        .clk     (clk),
        .reset   (reset),
        .i_clear (i_clear),
        .i_a     (a_link[r][c]),
        .i_b     (b_link[r][c]),
        .o_a     (a_link[r][c+1]),
        .o_b     (b_link[r+1][c]),
        .o_c     (o_results[(r*matmul_pkg::MAT_SIZE + c)*matmul_pkg::DWIDTH +:
                            matmul_pkg::DWIDTH])
      );
    end
  end

endmodule

//--- design/operand_feeder.sv
`timescale 1ns/1ps

module operand_feeder (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              i_fetch,
  input  logic [matmul_pkg::WORD_WIDTH-1:0] i_a_word,
  input  logic [matmul_pkg::WORD_WIDTH-1:0] i_b_word,
  output logic [matmul_pkg::WORD_WIDTH-1:0] o_a_lanes,
  output logic [matmul_pkg::WORD_WIDTH-1:0] o_b_lanes
);

  logic [matmul_pkg::WORD_WIDTH-1:0] a_gated;
  logic [matmul_pkg::WORD_WIDTH-1:0] b_gated;

  // memory words are only meaningful inside the read window
  assign a_gated = i_fetch ? i_a_word : '0;
  assign b_gated = i_fetch ? i_b_word : '0;

  genvar r;

  // lane r is held back r cycles to form the diagonal wavefront
  for (r = 0; r < matmul_pkg::MAT_SIZE; r++) begin : g_lane
    if (r == 0) begin : g_direct
      assign o_a_lanes[matmul_pkg::DWIDTH-1:0] = a_gated[matmul_pkg::DWIDTH-1:0];
      assign o_b_lanes[matmul_pkg::DWIDTH-1:0] = b_gated[matmul_pkg::DWIDTH-1:0];
    end else begin : g_delay
      logic [matmul_pkg::DWIDTH-1:0] a_dly [r];
      logic [matmul_pkg::DWIDTH-1:0] b_dly [r];

      always_ff @(posedge clk) begin
        if (reset) begin
          for (int s = 0; s < r; s++) begin
            a_dly[s] <= '0;
            b_dly[s] <= '0;
          end
        end else begin
          a_dly[0] <= a_gated[r*matmul_pkg::DWIDTH +: matmul_pkg::DWIDTH];
          b_dly[0] <= b_gated[r*matmul_pkg::DWIDTH +: matmul_pkg::DWIDTH];
          for (int s = 1; s < r; s++) begin
            a_dly[s] <= a_dly[s-1];
            b_dly[s] <= b_dly[s-1];
          end
        end
      end

      assign o_a_lanes[r*matmul_pkg::DWIDTH +: matmul_pkg::DWIDTH] = a_dly[r-1];
      assign o_b_lanes[r*matmul_pkg::DWIDTH +: matmul_pkg::DWIDTH] = b_dly[r-1];
    end
  end

endmodule

//--- design/matmul_control.sv
`timescale 1ns/1ps

module matmul_control (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          i_start,
  output logic                          o_rd_en,
  output logic [matmul_pkg::AWIDTH-1:0] o_rd_addr,
  output logic                          o_fetch,
  output logic                          o_clear,
  output logic                          o_latch,
  output logic                          o_done
);

  matmul_pkg::ctrl_state_t              state;
  logic [matmul_pkg::CNT_WIDTH-1:0]     cnt;

  ////////////////////////////////////////////////////////////////////////////
  // phase sequencing and read address
  ////////////////////////////////////////////////////////////////////////////

  // dropping start aborts whatever phase is running
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      state     <= matmul_pkg::ST_IDLE;
      cnt       <= '0;
      o_rd_addr <= matmul_pkg::ADDR_IDLE;
    end else begin
      case (state)
        matmul_pkg::ST_IDLE: begin
          state     <= matmul_pkg::ST_LOAD;
          cnt       <= '0;
          o_rd_addr <= o_rd_addr + matmul_pkg::ADDR_STEP;
        end
        matmul_pkg::ST_LOAD: begin
          if (cnt == matmul_pkg::MAT_LAST) begin
            state     <= matmul_pkg::ST_COMPUTE;
            cnt       <= '0;
            o_rd_addr <= matmul_pkg::ADDR_IDLE;
          end else begin
            cnt       <= cnt + 1'b1;
            o_rd_addr <= o_rd_addr + matmul_pkg::ADDR_STEP;
          end
        end
        matmul_pkg::ST_COMPUTE: begin
          if (cnt == matmul_pkg::COMPUTE_LAST) begin
            state <= matmul_pkg::ST_DRAIN;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        matmul_pkg::ST_DRAIN: begin
          if (cnt == matmul_pkg::MAT_LAST) begin
            state <= matmul_pkg::ST_DONE;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        // hold until start falls
        matmul_pkg::ST_DONE: begin
          state <= matmul_pkg::ST_DONE;
        end
        default: begin
          state <= matmul_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // memory data arrives one cycle after the read
  always_ff @(posedge clk) begin
    if (reset) begin
      o_fetch <= 1'b0;
    end else begin
      o_fetch <= o_rd_en;
    end
  end

  assign o_rd_en = (state == matmul_pkg::ST_LOAD);
  assign o_clear = !i_start;
  // pulse on the last compute cycle once every accumulator holds its final value
  assign o_latch = (state == matmul_pkg::ST_COMPUTE) && (cnt == matmul_pkg::COMPUTE_LAST);
  assign o_done  = (state == matmul_pkg::ST_DONE);

endmodule

//--- design/result_drain.sv
`timescale 1ns/1ps

module result_drain (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              i_latch,
  input  logic [matmul_pkg::MAT_SIZE*matmul_pkg::MAT_SIZE*matmul_pkg::DWIDTH-1:0] i_results,
  output logic [matmul_pkg::WORD_WIDTH-1:0] o_c_word,
  output logic [matmul_pkg::AWIDTH-1:0]     o_c_addr,
  output logic                              o_c_valid
);

  logic [matmul_pkg::WORD_WIDTH-1:0]         columns [matmul_pkg::MAT_SIZE];
  logic [$clog2(matmul_pkg::MAT_SIZE)-1:0]   col;

  // regroup the row-major grid into column words, row r in lane r
  always_ff @(posedge clk) begin
    if (i_latch) begin
      for (int c = 0; c < matmul_pkg::MAT_SIZE; c++) begin
        for (int r = 0; r < matmul_pkg::MAT_SIZE; r++) begin
          columns[c][r*matmul_pkg::DWIDTH +: matmul_pkg::DWIDTH] <=
            i_results[(r*matmul_pkg::MAT_SIZE + c)*matmul_pkg::DWIDTH +: matmul_pkg::DWIDTH];
        end
      end
    end
  end

  // unload sequencer steps one column per cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      o_c_valid <= 1'b0;
      col       <= '0;
      o_c_addr  <= '0;
    end else if (i_latch) begin
      o_c_valid <= 1'b1;
      col       <= '0;
      o_c_addr  <= '0;
    end else if (o_c_valid) begin
      col      <= col + 1'b1;
      o_c_addr <= o_c_addr + matmul_pkg::ADDR_STEP;
      if (&col) begin
        o_c_valid <= 1'b0;
      end
    end
  end

  assign o_c_word = columns[col];

endmodule

//--- design/matmul_4x4.sv
`timescale 1ns/1ps

module matmul_4x4 (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              i_start,
  input  logic [matmul_pkg::WORD_WIDTH-1:0] i_a_word,
  input  logic [matmul_pkg::WORD_WIDTH-1:0] i_b_word,
  output logic                              o_rd_en,
  output logic [matmul_pkg::AWIDTH-1:0]     o_rd_addr,
  output logic [matmul_pkg::WORD_WIDTH-1:0] o_c_word,
  output logic [matmul_pkg::AWIDTH-1:0]     o_c_addr,
  output logic                              o_c_valid,
  output logic                              o_done
);

  logic                              fetch;
  logic                              clear;
  logic                              latch;
  logic [matmul_pkg::WORD_WIDTH-1:0] a_lanes;
  logic [matmul_pkg::WORD_WIDTH-1:0] b_lanes;
  logic [matmul_pkg::MAT_SIZE*matmul_pkg::MAT_SIZE*matmul_pkg::DWIDTH-1:0] results;

  matmul_control u_control (
    .clk       (clk),
    .reset     (reset),
    .i_start   (i_start),
    .o_rd_en   (o_rd_en),
    .o_rd_addr (o_rd_addr),
    .o_fetch   (fetch),
    .o_clear   (clear),
    .o_latch   (latch),
    .o_done    (o_done)
  );

  operand_feeder u_feeder (
    .clk       (clk),
    .reset     (reset),
    .i_fetch   (fetch),
    .i_a_word  (i_a_word),
    .i_b_word  (i_b_word),
    .o_a_lanes (a_lanes),
    .o_b_lanes (b_lanes)
  );

  systolic_array u_array (
    .clk       (clk),
    .reset     (reset),
    .i_clear   (clear),
    .i_a_lanes (a_lanes),
    .i_b_lanes (b_lanes),
    .o_results (results)
  );

  result_drain u_drain (
    .clk       (clk),
    .reset     (reset),
    .i_latch   (latch),
    .i_results (results),
    .o_c_word  (o_c_word),
    .o_c_addr  (o_c_addr),
    .o_c_valid (o_c_valid)
  );

endmodule

//--- bench/matmul_4x4_properties.sv
`timescale 1ns/1ps

module matmul_4x4_properties (
  input logic clk,
  input logic reset,
  input logic i_rd_en,
  input logic i_c_valid,
  input logic i_done
);

  // reads and result unload belong to different phases
  a_no_read_during_unload: assert property (
    @(posedge clk) disable iff (reset) !(i_c_valid && i_rd_en)
  ) else $error("result strobe high during a memory read");

  // done only once the unload has finished
  a_done_after_unload: assert property (
    @(posedge clk) disable iff (reset) !(i_done && i_c_valid)
  ) else $error("done high while results are still streaming");

  a_quiet_after_reset: assert property (
    @(posedge clk) reset |=> (!i_rd_en && !i_c_valid && !i_done)
  ) else $error("control outputs not idle after reset");

endmodule

// the top level ports are driven straight from u_control and u_drain
bind matmul_4x4 matmul_4x4_properties u_properties (
  .clk       (clk),
  .reset     (reset),
  .i_rd_en   (o_rd_en),
  .i_c_valid (o_c_valid),
  .i_done    (o_done)
);

//--- bench/matmul_4x4_tb.sv
`timescale 1ns/1ps

module matmul_4x4_tb;

  logic                              clk = 1'b0;
  logic                              reset = 1'b1;
  logic                              i_start = 1'b0;
  logic [matmul_pkg::WORD_WIDTH-1:0] i_a_word = '0;
  logic [matmul_pkg::WORD_WIDTH-1:0] i_b_word = '0;
  logic                              o_rd_en;
  logic [matmul_pkg::AWIDTH-1:0]     o_rd_addr;
  logic [matmul_pkg::WORD_WIDTH-1:0] o_c_word;
  logic [matmul_pkg::AWIDTH-1:0]     o_c_addr;
  logic                              o_c_valid;
  logic                              o_done;

  logic signed [7:0]                 a_mat [matmul_pkg::MAT_SIZE][matmul_pkg::MAT_SIZE];
  logic signed [7:0]                 b_mat [matmul_pkg::MAT_SIZE][matmul_pkg::MAT_SIZE];
  logic [7:0]                        exp_c [matmul_pkg::MAT_SIZE][matmul_pkg::MAT_SIZE];
  logic [matmul_pkg::WORD_WIDTH-1:0] mem_a [matmul_pkg::MAT_SIZE];
  logic [matmul_pkg::WORD_WIDTH-1:0] mem_b [matmul_pkg::MAT_SIZE];
  logic                              rd_pending = 1'b0;
  logic [1:0]                        rd_index = '0;
  logic [matmul_pkg::AWIDTH-1:0]     rd_addrs [$];
  int                                result_count = 0;
  int                                run_total = 5;

  matmul_4x4 i_dut (
    .clk       (clk),
    .reset     (reset),
    .i_start   (i_start),
    .i_a_word  (i_a_word),
    .i_b_word  (i_b_word),
    .o_rd_en   (o_rd_en),
    .o_rd_addr (o_rd_addr),
    .o_c_word  (o_c_word),
    .o_c_addr  (o_c_addr),
    .o_c_valid (o_c_valid),
    .o_done    (o_done)
  );

  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED time=%0t signal=%s expected=0x%0h actual=0x%0h",
               $time, name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // saturate each product to 8 bits, wrap after every add, k in order
  function automatic logic [7:0] expected_element(input int row, input int col);
    int         product;
    int         narrowed;
    logic [7:0] acc;
    acc = 8'd0;
    for (int k = 0; k < matmul_pkg::MAT_SIZE; k++) begin
      product = int'(a_mat[row][k]) * int'(b_mat[k][col]);
      if (product > 127) begin
        narrowed = 127;
      end else if (product < -128) begin
        narrowed = -128;
      end else begin
        narrowed = product;
      end
      acc = acc + narrowed[7:0];
    end
    return acc;
  endfunction

  // word k of A is column k, word k of B is row k
  task automatic load_memories(input bit expect_b);
    for (int k = 0; k < matmul_pkg::MAT_SIZE; k++) begin
      for (int r = 0; r < matmul_pkg::MAT_SIZE; r++) begin
        mem_a[k][r*8 +: 8] = a_mat[r][k];
        mem_b[k][r*8 +: 8] = b_mat[k][r];
      end
    end
    for (int r = 0; r < matmul_pkg::MAT_SIZE; r++) begin
      for (int c = 0; c < matmul_pkg::MAT_SIZE; c++) begin
        exp_c[r][c] = expect_b ? b_mat[r][c] : expected_element(r, c);
      end
    end
  endtask

  task automatic fill_matrices(input int mode, input logic [7:0] a_val,
                               input logic [7:0] b_val);
    for (int r = 0; r < matmul_pkg::MAT_SIZE; r++) begin
      for (int c = 0; c < matmul_pkg::MAT_SIZE; c++) begin
        if (mode == 0) begin
          a_mat[r][c] = (r == c) ? 8'sd1 : 8'sd0;
          b_mat[r][c] = $signed(8'($urandom_range(15))) - 8'sd8;
        end else if (mode == 1) begin
          a_mat[r][c] = a_val;
          b_mat[r][c] = b_val;
        end else begin
          a_mat[r][c] = 8'($urandom());
          b_mat[r][c] = 8'($urandom());
        end
      end
    end
  endtask

  task automatic run_matrix();
    result_count = 0;
    rd_addrs.delete();
    @(negedge clk);
    i_start = 1'b1;
    while (!o_done) @(negedge clk);
    check_value("o_c_valid count", 32'(result_count), 32'd4);
    check_value("o_rd_en count", 32'(rd_addrs.size()), 32'd4);
    for (int i = 0; i < rd_addrs.size(); i++) begin
      check_value("o_rd_addr", 32'(rd_addrs[i]), 32'(4 * i));
    end
    // done holds while start stays high
    repeat (3) begin
      @(negedge clk);
      check_value("o_done", 32'(o_done), 32'd1);
    end
    i_start = 1'b0;
    @(negedge clk);
    check_value("o_done", 32'(o_done), 32'd0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // memory model with one cycle of read latency and junk outside the window
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rd_pending) begin
      i_a_word <= mem_a[rd_index];
      i_b_word <= mem_b[rd_index];
    end else begin
      i_a_word <= $urandom();
      i_b_word <= $urandom();
    end
    rd_pending <= o_rd_en;
    rd_index   <= o_rd_addr[3:2];
    if (o_rd_en) begin
      rd_addrs.push_back(o_rd_addr);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // result comparison
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (o_c_valid) begin
      if (result_count >= matmul_pkg::MAT_SIZE) begin
        $display("more than four result words arrived in one run");
        $display("TEST RESULT: FAIL");
        $fatal(1, "too many results");
      end
      check_value("o_c_addr", 32'(o_c_addr), 32'(4 * result_count));
      for (int r = 0; r < matmul_pkg::MAT_SIZE; r++) begin
        check_value($sformatf("o_c_word[col %0d][row %0d]", result_count, r),
                    32'(o_c_word[r*8 +: 8]), 32'(exp_c[r][result_count]));
      end
      result_count++;
    end
    if (o_done) begin
      check_value("result words before o_done", 32'(result_count), 32'd4);
    end
  end

  initial begin
    repeat (run_total * 200) @(posedge clk);
    $display("watchdog expired, the runs did not finish in %0d cycles", run_total * 200);
    $display("TEST RESULT: FAIL");
    $fatal(1, "timeout");
  end

  initial begin
    void'($urandom(34500));
    repeat (10) @(negedge clk);
    reset = 1'b0;
    // idle with start low
    repeat (5) begin
      @(negedge clk);
      check_value("o_rd_en", 32'(o_rd_en), 32'd0);
      check_value("o_c_valid", 32'(o_c_valid), 32'd0);
      check_value("o_done", 32'(o_done), 32'd0);
      check_value("o_rd_addr", 32'(o_rd_addr), 32'(matmul_pkg::ADDR_IDLE));
    end
    fill_matrices(0, 8'd0, 8'd0);
    load_memories(1'b1);
    run_matrix();
    // both saturation directions with wrap on the sums
    fill_matrices(1, 8'h80, 8'h80);
    load_memories(1'b0);
    run_matrix();
    fill_matrices(1, 8'h80, 8'h7f);
    load_memories(1'b0);
    run_matrix();
    // back to back random runs
    repeat (2) begin
      fill_matrices(2, 8'd0, 8'd0);
      load_memories(1'b0);
      run_matrix();
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- build.f
design/matmul_pkg.sv
design/mac_unit.sv
design/processing_element.sv
design/systolic_array.sv
design/operand_feeder.sv
design/matmul_control.sv
design/result_drain.sv
design/matmul_4x4.sv
bench/matmul_4x4_properties.sv
bench/matmul_4x4_tb.sv

//--- run.sh
#!/bin/sh
# build and run the matmul_4x4 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module matmul_4x4_tb \
  -f build.f -o matmul_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

sim_output=$(./obj_dir/matmul_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
exit 1
